//--- Makefile
# Verilator build and run of the element unit testbench

VERILATOR ?= verilator
TOP       ?= elem_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_LINE ?= STATUS: PASS

.PHONY: sim clean

# build, run, and succeed only when the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_LINE)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/elem_cfg_pkg.sv
//////////////////////////////
// register file geometry and element sizing for the element unit
// operand slicing in the RTL assumes VREG_W of 128 and XLEN of 32
//////////////////////////////
`default_nettype none

package elem_cfg_pkg;

    //////////////////////////////
    // register file

    // vector register width and its byte count
    localparam int unsigned VREG_W      = 128;
    localparam int unsigned VREG_BYTES  = VREG_W / 8;
    localparam int unsigned VREG_ADDR_W = 5;

    // scalar result width of the main core
    localparam int unsigned XLEN = 32;

    //////////////////////////////
    // counters

    // byte counter over a group of up to 8 registers
    localparam int unsigned ELEM_CNT_W = 7;
    localparam int unsigned GRP_IDX_W  = 3;
    localparam int unsigned BYTE_IDX_W = ELEM_CNT_W - GRP_IDX_W;

    // vector length, enough for 128 byte elements
    localparam int unsigned VL_W = 8;

    //////////////////////////////
    // configuration types

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_t;

    // register group size
    typedef enum logic [1:0] {
        EMUL_1 = 2'd0,
        EMUL_2 = 2'd1,
        EMUL_4 = 2'd2,
        EMUL_8 = 2'd3
    } emul_t;

endpackage

`default_nettype wire

//--- common/elem_op_pkg.sv
//////////////////////////////
// operation encoding for the element unit
// every operation other than xmv reduces a register group to a scalar
//////////////////////////////
`default_nettype none

package elem_op_pkg;

    //////////////////////////////
    // operations

    typedef enum logic [3:0] {
        // element 0 of vs2 to a scalar, sign-extended
        OP_XMV     = 4'd0,
        // bitwise and arithmetic reductions
        OP_REDSUM  = 4'd1,
        OP_REDAND  = 4'd2,
        OP_REDOR   = 4'd3,
        OP_REDXOR  = 4'd4,
        // compare reductions, unsigned and signed
        OP_REDMINU = 4'd5,
        OP_REDMIN  = 4'd6,
        OP_REDMAXU = 4'd7,
        OP_REDMAX  = 4'd8
    } elem_op_t;

    //////////////////////////////
    // classification

    // reductions take an initial value from vs1 and walk the whole group
    function automatic logic op_is_reduction(input elem_op_t op);
        logic red;
        case (op)
            OP_REDSUM,
            OP_REDAND,
            OP_REDOR,
            OP_REDXOR,
            OP_REDMINU,
            OP_REDMIN,
            OP_REDMAXU,
            OP_REDMAX: red = 1'b1;
            default:   red = 1'b0;
        endcase
        return red;
    endfunction

endpackage

`default_nettype wire

//--- elem_seq/elem_sequencer.sv
//////////////////////////////
// one element per cycle, a reduction is preceded by one vs1 read cycle
// vs2 must be aligned to the group size
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module elem_sequencer
    import elem_cfg_pkg::*;
    import elem_op_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    input  wire logic                   op_rdy_i,
    output logic                        op_ack_o,
    input  wire elem_op_t               op_i,
    input  wire sew_t                   sew_i,
    input  wire emul_t                  emul_i,
    input  wire logic [VL_W-1:0]        vl_i,
    input  wire logic [VREG_ADDR_W-1:0] vs1_i,
    input  wire logic [VREG_ADDR_W-1:0] vs2_i,

    output logic [VREG_ADDR_W-1:0]      vreg_rd_addr_o,

    output logic                        seq_valid_o,
    output logic                        seq_first_o,
    output logic                        seq_last_o,
    output logic                        seq_load_o,
    output logic                        seq_active_o,
    output sew_t                        seq_sew_o,
    output elem_op_t                    seq_op_o
);

    // element bytes minus one, also the byte offset of the first element's top byte
    function automatic logic [1:0] sew_m1(input sew_t sew);
        logic [1:0] m1;
        case (sew)
            SEW_8:   m1 = 2'd0;
            SEW_16:  m1 = 2'd1;
            default: m1 = 2'd3;
        endcase
        return m1;
    endfunction

    //////////////////////////////
    // state

    logic                   busy_q;
    logic                   init_q;
    // counter points at the top byte of the current element
    logic [ELEM_CNT_W-1:0]  cnt_q;
    logic [VL_W-1:0]        idx_q;
    elem_op_t               op_q;
    sew_t                   sew_q;
    emul_t                  emul_q;
    logic [VL_W-1:0]        vl_q;
    logic [VREG_ADDR_W-1:0] vs1_q;
    logic [VREG_ADDR_W-1:0] vs2_q;

    logic [GRP_IDX_W-1:0]   grp_idx;
    logic [BYTE_IDX_W-1:0]  byte_idx;
    logic                   grp_last;
    logic                   last_elem;
    logic                   elem_cycle;
    logic                   accept;
    logic [ELEM_CNT_W-1:0]  cnt_step;

    assign grp_idx  = cnt_q[ELEM_CNT_W-1 -: GRP_IDX_W];
    assign byte_idx = cnt_q[BYTE_IDX_W-1:0];
    assign cnt_step = {{(ELEM_CNT_W-2){1'b0}}, sew_m1(sew_q)} + 1'b1;

    always_comb begin
        case (emul_q)
            EMUL_1:  grp_last = 1'b1;
            EMUL_2:  grp_last = grp_idx[0];
            EMUL_4:  grp_last = &grp_idx[1:0];
            default: grp_last = &grp_idx;
        endcase
    end

    // xmv stops after element 0
    assign last_elem  = (op_q == OP_XMV) | ((byte_idx == '1) & grp_last);
    assign elem_cycle = busy_q & ~init_q;

    // next operation may start while the last element goes out
    assign op_ack_o = ~busy_q | (elem_cycle & last_elem);
    assign accept   = op_rdy_i & op_ack_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            init_q <= 1'b0;
            cnt_q  <= '0;
            idx_q  <= '0;
            op_q   <= OP_XMV;
            sew_q  <= SEW_8;
            emul_q <= EMUL_1;
            vl_q   <= '0;
            vs1_q  <= '0;
            vs2_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            init_q <= op_is_reduction(op_i);
            cnt_q  <= {{(ELEM_CNT_W-2){1'b0}}, sew_m1(sew_i)};
            idx_q  <= '0;
            op_q   <= op_i;
            sew_q  <= sew_i;
            emul_q <= emul_i;
            vl_q   <= vl_i;
            vs1_q  <= vs1_i;
            vs2_q  <= vs2_i;
        end else if (init_q) begin
            init_q <= 1'b0;
        end else if (busy_q) begin
            if (last_elem) begin
                busy_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q + cnt_step;
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    //////////////////////////////
    // outputs

    // vs1 in the initial-value cycle, then the registers of the vs2 group
    assign vreg_rd_addr_o = init_q ? vs1_q :
                            vs2_q + {{(VREG_ADDR_W-GRP_IDX_W){1'b0}}, grp_idx};

    assign seq_valid_o  = elem_cycle;
    assign seq_first_o  = elem_cycle & (idx_q == '0);
    assign seq_last_o   = elem_cycle & last_elem;
    // a fresh register is needed when the counter sits on its first element
    assign seq_load_o   = init_q |
                          (elem_cycle & (byte_idx == {{(BYTE_IDX_W-2){1'b0}}, sew_m1(sew_q)}));
    assign seq_active_o = idx_q < vl_q;
    assign seq_sew_o    = sew_q;
    assign seq_op_o     = op_q;

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verif
common/elem_cfg_pkg.sv
common/elem_op_pkg.sv
elem_seq/elem_sequencer.sv
source/elem_operand.sv
source/elem_reduce.sv
source/elem_unit.sv
verif/elem_tb.sv

//--- source/elem_operand.sv
//////////////////////////////
// holds the fetched register and peels off one element per cycle
// elements come out zero-extended to XLEN
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module elem_operand
    import elem_cfg_pkg::*;
    import elem_op_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    input  wire logic [VREG_W-1:0] vreg_rd_i,

    input  wire logic              seq_valid_i,
    input  wire logic              seq_first_i,
    input  wire logic              seq_last_i,
    input  wire logic              seq_load_i,
    input  wire logic              seq_active_i,
    input  wire sew_t              seq_sew_i,
    input  wire elem_op_t          seq_op_i,

    output logic                   op_valid_o,
    output logic                   op_first_o,
    output logic                   op_last_o,
    output logic                   op_active_o,
    output sew_t                   op_sew_o,
    output elem_op_t               op_kind_o,
    output logic [XLEN-1:0]        elem_o,
    output logic [XLEN-1:0]        init_o
);

    // lowest element of a register at the given width
    function automatic logic [XLEN-1:0] low_elem(input logic [VREG_W-1:0] v, input sew_t sew);
        logic [XLEN-1:0] e;
        case (sew)
            SEW_8:   e = {{(XLEN-8){1'b0}}, v[7:0]};
            SEW_16:  e = {{(XLEN-16){1'b0}}, v[15:0]};
            default: e = v[XLEN-1:0];
        endcase
        return e;
    endfunction

    logic [VREG_W-1:0] shift_q;
    logic [VREG_W-1:0] cur;
    logic [VREG_W-1:0] shift_d;

    // a new register replaces what is left of the old one
    assign cur = seq_load_i ? vreg_rd_i : shift_q;

    always_comb begin
        case (seq_sew_i)
            SEW_8:   shift_d = cur >> 8;
            SEW_16:  shift_d = cur >> 16;
            default: shift_d = cur >> 32;
        endcase
    end

    //////////////////////////////
    // stage registers

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            op_valid_o  <= 1'b0;
            op_first_o  <= 1'b0;
            op_last_o   <= 1'b0;
            op_active_o <= 1'b0;
        end else begin
            op_valid_o  <= seq_valid_i;
            op_first_o  <= seq_first_i;
            op_last_o   <= seq_last_i;
            op_active_o <= seq_active_i;
        end
    end

    always_ff @(posedge clk_i) begin
        op_sew_o  <= seq_sew_i;
        op_kind_o <= seq_op_i;
        if (seq_valid_i) begin
            shift_q <= shift_d;
            elem_o  <= low_elem(cur, seq_sew_i);
        end
        // load without an element is the vs1 read of a reduction
        if (seq_load_i && !seq_valid_i) begin
            init_o <= low_elem(vreg_rd_i, seq_sew_i);
        end
    end

endmodule

`default_nettype wire

//--- source/elem_reduce.sv
//////////////////////////////
// accumulates elements at the element width, upper bits follow the initial value
// xreg_o is held until the next operation's first element lands
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module elem_reduce
    import elem_cfg_pkg::*;
    import elem_op_pkg::*;
(
    input  wire logic            clk_i,
    input  wire logic            rst_ni,

    input  wire logic            op_valid_i,
    input  wire logic            op_first_i,
    input  wire logic            op_last_i,
    input  wire logic            op_active_i,
    input  wire sew_t            op_sew_i,
    input  wire elem_op_t        op_kind_i,
    input  wire logic [XLEN-1:0] elem_i,
    input  wire logic [XLEN-1:0] init_i,

    output logic                 xreg_valid_o,
    output logic [XLEN-1:0]      xreg_o
);

    // widen one element by a bit so signed and unsigned compares share a comparator
    function automatic logic [XLEN:0] ext_elem(input logic [XLEN-1:0] v, input sew_t sew,
                                               input logic sgn);
        logic [XLEN:0] r;
        case (sew)
            SEW_8:   r = {{(XLEN-7){sgn & v[7]}}, v[7:0]};
            SEW_16:  r = {{(XLEN-15){sgn & v[15]}}, v[15:0]};
            default: r = {sgn & v[XLEN-1], v};
        endcase
        return r;
    endfunction

    logic [XLEN-1:0] acc_q;
    logic [XLEN-1:0] acc_d;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] wmask;
    logic [XLEN-1:0] comb;
    logic [XLEN:0]   elem_x;
    logic [XLEN:0]   base_x;
    logic [XLEN:0]   xmv_x;
    logic            signed_cmp;
    logic            elem_lt;

    //////////////////////////////
    // combine

    // first element starts over from the vs1 value
    assign base = op_first_i ? init_i : acc_q;

    always_comb begin
        case (op_sew_i)
            SEW_8:   wmask = XLEN'(8'hff);
            SEW_16:  wmask = XLEN'(16'hffff);
            default: wmask = '1;
        endcase
    end

    assign signed_cmp = (op_kind_i == OP_REDMIN) | (op_kind_i == OP_REDMAX);
    assign elem_x     = ext_elem(elem_i, op_sew_i, signed_cmp);
    assign base_x     = ext_elem(base, op_sew_i, signed_cmp);
    assign elem_lt    = $signed(elem_x) < $signed(base_x);
    assign xmv_x      = ext_elem(elem_i, op_sew_i, 1'b1);

    always_comb begin
        case (op_kind_i)
            OP_REDSUM:  comb = elem_i + base;
            OP_REDAND:  comb = elem_i & base;
            OP_REDOR:   comb = elem_i | base;
            OP_REDXOR:  comb = elem_i ^ base;
            OP_REDMINU,
            OP_REDMIN:  comb = elem_lt ? elem_i : base;
            OP_REDMAXU,
            OP_REDMAX:  comb = elem_lt ? base : elem_i;
            default:    comb = base;
        endcase

        if (op_kind_i == OP_XMV) begin
            acc_d = xmv_x[XLEN-1:0];
        end else if (op_active_i) begin
            // only the element width changes
            acc_d = (base & ~wmask) | (comb & wmask);
        end else begin
            acc_d = base;
        end
    end

    //////////////////////////////
    // result

    always_ff @(posedge clk_i) begin
        if (op_valid_i) begin
            acc_q <= acc_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            xreg_valid_o <= 1'b0;
        end else begin
            xreg_valid_o <= op_valid_i & op_last_i;
        end
    end

    assign xreg_o = acc_q;

endmodule

`default_nettype wire

//--- source/elem_unit.sv
//////////////////////////////
// element unit, sequencer then operand stage then reduce stage
// the register file must answer vreg_rd_addr_o in the same cycle
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module elem_unit
    import elem_cfg_pkg::*;
    import elem_op_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // issue handshake
    input  wire logic                   op_rdy_i,
    output logic                        op_ack_o,
    input  wire elem_op_t               op_i,
    input  wire sew_t                   sew_i,
    input  wire emul_t                  emul_i,
    input  wire logic [VL_W-1:0]        vl_i,
    input  wire logic [VREG_ADDR_W-1:0] vs1_i,
    input  wire logic [VREG_ADDR_W-1:0] vs2_i,

    // register file read port
    output logic [VREG_ADDR_W-1:0]      vreg_rd_addr_o,
    input  wire logic [VREG_W-1:0]      vreg_rd_i,

    // scalar result
    output logic                        xreg_valid_o,
    output logic [XLEN-1:0]             xreg_o
);

    // sequencer to operand stage
    logic     seq_valid;
    logic     seq_first;
    logic     seq_last;
    logic     seq_load;
    logic     seq_active;
    sew_t     seq_sew;
    elem_op_t seq_op;

    // operand stage to reduce stage
    logic            op_valid;
    logic            op_first;
    logic            op_last;
    logic            op_active;
    sew_t            op_sew;
    elem_op_t        op_kind;
    logic [XLEN-1:0] elem;
    logic [XLEN-1:0] init;

    elem_sequencer u_seq (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_ack_o       (op_ack_o),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .emul_i         (emul_i),
        .vl_i           (vl_i),
        .vs1_i          (vs1_i),
        .vs2_i          (vs2_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .seq_valid_o    (seq_valid),
        .seq_first_o    (seq_first),
        .seq_last_o     (seq_last),
        .seq_load_o     (seq_load),
        .seq_active_o   (seq_active),
        .seq_sew_o      (seq_sew),
        .seq_op_o       (seq_op)
    );

    elem_operand u_operand (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .vreg_rd_i    (vreg_rd_i),
        .seq_valid_i  (seq_valid),
        .seq_first_i  (seq_first),
        .seq_last_i   (seq_last),
        .seq_load_i   (seq_load),
        .seq_active_i (seq_active),
        .seq_sew_i    (seq_sew),
        .seq_op_i     (seq_op),
        .op_valid_o   (op_valid),
        .op_first_o   (op_first),
        .op_last_o    (op_last),
        .op_active_o  (op_active),
        .op_sew_o     (op_sew),
        .op_kind_o    (op_kind),
        .elem_o       (elem),
        .init_o       (init)
    );

    elem_reduce u_reduce (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .op_valid_i   (op_valid),
        .op_first_i   (op_first),
        .op_last_i    (op_last),
        .op_active_i  (op_active),
        .op_sew_i     (op_sew),
        .op_kind_i    (op_kind),
        .elem_i       (elem),
        .init_i       (init),
        .xreg_valid_o (xreg_valid_o),
        .xreg_o       (xreg_o)
    );

endmodule

`default_nettype wire

//--- verif/elem_tb_ref.svh
//////////////////////////////
// expected results and typed compares, included inside elem_tb
// needs vreg_mem and abort_run in the including scope
//////////////////////////////
`ifndef ELEM_TB_REF_SVH
`define ELEM_TB_REF_SVH

// bytes in one element
function automatic int unsigned elem_bytes(input sew_t sew);
    case (sew)
        SEW_8:   return 1;
        SEW_16:  return 2;
        default: return 4;
    endcase
endfunction

// elements in a whole register group
function automatic int unsigned group_elems(input sew_t sew, input emul_t emul);
    return (VREG_BYTES / elem_bytes(sew)) << emul;
endfunction

function automatic logic [XLEN-1:0] width_mask(input sew_t sew);
    return XLEN'((64'd1 << (8 * elem_bytes(sew))) - 64'd1);
endfunction

function automatic logic [XLEN-1:0] sign_extend(input logic [XLEN-1:0] v, input sew_t sew);
    logic [XLEN-1:0] mask;
    logic [XLEN-1:0] top;
    mask = width_mask(sew);
    top  = mask ^ (mask >> 1);
    if ((v & top) != '0) begin
        return v | ~mask;
    end
    return v;
endfunction

// element idx of the group starting at base, zero-extended
function automatic logic [XLEN-1:0] group_elem(input logic [VREG_ADDR_W-1:0] base,
                                               input int unsigned idx, input sew_t sew);
    int unsigned            byte_pos;
    logic [VREG_ADDR_W-1:0] reg_idx;
    logic [VREG_W-1:0]      word;
    byte_pos = idx * elem_bytes(sew);
    reg_idx  = base + VREG_ADDR_W'(byte_pos / VREG_BYTES);
    word     = vreg_mem[reg_idx];
    return XLEN'(word >> (8 * (byte_pos % VREG_BYTES))) & width_mask(sew);
endfunction

//////////////////////////////
// expected scalar

function automatic logic [XLEN-1:0] ref_result(input elem_op_t op, input sew_t sew,
                                               input emul_t emul, input logic [VL_W-1:0] vl,
                                               input logic [VREG_ADDR_W-1:0] vs1,
                                               input logic [VREG_ADDR_W-1:0] vs2);
    logic [XLEN-1:0] mask;
    logic [XLEN-1:0] acc;
    logic [XLEN-1:0] e;
    int unsigned     i;
    mask = width_mask(sew);
    if (op == OP_XMV) begin
        return sign_extend(group_elem(vs2, 0, sew), sew);
    end
    // start from element 0 of vs1, upper bits stay zero
    acc = group_elem(vs1, 0, sew);
    for (i = 0; i < group_elems(sew, emul) && i < vl; i++) begin
        e = group_elem(vs2, i, sew);
        case (op)
            OP_REDSUM:  acc = (acc + e) & mask;
            OP_REDAND:  acc = acc & e;
            OP_REDOR:   acc = acc | e;
            OP_REDXOR:  acc = acc ^ e;
            OP_REDMINU: acc = (e < acc) ? e : acc;
            OP_REDMAXU: acc = (e > acc) ? e : acc;
            OP_REDMIN:  acc = ($signed(sign_extend(e, sew)) < $signed(sign_extend(acc, sew)))
                              ? e : acc;
            OP_REDMAX:  acc = ($signed(sign_extend(e, sew)) > $signed(sign_extend(acc, sew)))
                              ? e : acc;
            default:    acc = acc;
        endcase
    end
    return acc;
endfunction

//////////////////////////////
// compares

task automatic check_xreg(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("FAILED xreg_o got 0x%08h expected 0x%08h", got, exp));
    end
endtask

task automatic check_ack(input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("FAILED op_ack_o got 0x%0h expected 0x%0h", got, exp));
    end
endtask

`endif

//--- verif/elem_tb.sv
//////////////////////////////
// results are checked in issue order and each at its exact latency
// register file is random and fixed for the whole run
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module elem_tb
    import elem_cfg_pkg::*;
    import elem_op_pkg::*;
();

    localparam int unsigned ISSUE_LIMIT = 300;
    localparam int unsigned DRAIN_LIMIT = 400;
    localparam int unsigned STREAM_OPS  = 40;

    logic                   clk_i = 1'b0;
    logic                   rst_ni;
    logic                   op_rdy_i;
    logic                   op_ack_o;
    elem_op_t               op_i;
    sew_t                   sew_i;
    emul_t                  emul_i;
    logic [VL_W-1:0]        vl_i;
    logic [VREG_ADDR_W-1:0] vs1_i;
    logic [VREG_ADDR_W-1:0] vs2_i;
    logic [VREG_ADDR_W-1:0] vreg_rd_addr_o;
    logic [VREG_W-1:0]      vreg_rd_i;
    logic                   xreg_valid_o;
    logic [XLEN-1:0]        xreg_o;

    // register file model
    logic [VREG_W-1:0]      vreg_mem [32];

    integer                 seed;
    int unsigned            cycle = 0;
    // last element cycle of the newest accepted operation
    int unsigned            free_cycle = 0;
    // expected value and due cycle of every accepted operation
    logic [XLEN-1:0]        exp_val_q [$];
    int unsigned            exp_due_q [$];

    elem_unit UUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_ack_o       (op_ack_o),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .emul_i         (emul_i),
        .vl_i           (vl_i),
        .vs1_i          (vs1_i),
        .vs2_i          (vs2_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .vreg_rd_i      (vreg_rd_i),
        .xreg_valid_o   (xreg_valid_o),
        .xreg_o         (xreg_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    assign vreg_rd_i = vreg_mem[vreg_rd_addr_o];

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

`include "elem_tb_ref.svh"

    function automatic int unsigned rand_below(input int unsigned bound);
        int unsigned r;
        r = $random(seed);
        return r % bound;
    endfunction

    function automatic logic [VREG_ADDR_W-1:0] rand_reg();
        return VREG_ADDR_W'(rand_below(32));
    endfunction

    // group base aligned to the group size
    function automatic logic [VREG_ADDR_W-1:0] aligned_reg(input emul_t emul);
        logic [VREG_ADDR_W-1:0] r;
        r = rand_reg();
        return (r >> emul) << emul;
    endfunction

    task automatic fill_regs();
        int r;
        for (r = 0; r < 32; r++) begin
            vreg_mem[r] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
    endtask

    //////////////////////////////
    // issue and drain

    // called just after a rising edge and returns just after the accepting edge
    task automatic issue(input elem_op_t op, input sew_t sew, input emul_t emul,
                         input logic [VL_W-1:0] vl, input logic [VREG_ADDR_W-1:0] vs1,
                         input logic [VREG_ADDR_W-1:0] vs2);
        int unsigned waited;
        int unsigned lat;
        logic        taken;
        op_rdy_i <= 1'b1;
        op_i     <= op;
        sew_i    <= sew;
        emul_i   <= emul;
        vl_i     <= vl;
        vs1_i    <= vs1;
        vs2_i    <= vs2;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            if (waited == ISSUE_LIMIT) begin
                abort_run("operation was not accepted before the timeout");
            end
            @(negedge clk_i);
            // acknowledge is due once the operation in flight reaches its last element
            check_ack(op_ack_o, cycle >= free_cycle);
            taken = (op_ack_o === 1'b1);
            waited++;
            if (taken) begin
                lat = (op == OP_XMV) ? 3 : group_elems(sew, emul) + 3;
                exp_val_q.push_back(ref_result(op, sew, emul, vl, vs1, vs2));
                exp_due_q.push_back(cycle + lat);
                free_cycle = cycle + lat - 2;
            end
            @(posedge clk_i);
        end
    endtask

    task automatic wait_drained();
        int unsigned waited;
        op_rdy_i <= 1'b0;
        waited = 0;
        while (exp_val_q.size() != 0) begin
            if (waited == DRAIN_LIMIT) begin
                abort_run("results still outstanding after the drain timeout");
            end
            @(posedge clk_i);
            waited++;
        end
        @(posedge clk_i);
    endtask

    //////////////////////////////
    // compare process

    always @(negedge clk_i) begin : compare
        logic [XLEN-1:0] exp_val;
        int unsigned     exp_due;
        if (xreg_valid_o !== 1'b0) begin
            if (exp_val_q.size() == 0) begin
                abort_run("result pulse with no operation outstanding");
            end else begin
                exp_val = exp_val_q.pop_front();
                exp_due = exp_due_q.pop_front();
                if (cycle != exp_due) begin
                    abort_run($sformatf("result arrived in cycle %0d, expected in cycle %0d",
                                        cycle, exp_due));
                end
                check_xreg(xreg_o, exp_val);
            end
        end
    end

    initial begin : stimulus
        int          k;
        int          s;
        int          g;
        int unsigned rep;
        sew_t        sew;
        emul_t       emul;
        logic [VL_W-1:0] vl;
        seed     = 32'h36ea625f;
        rst_ni   = 1'b0;
        op_rdy_i = 1'b0;
        op_i     = OP_XMV;
        sew_i    = SEW_8;
        emul_i   = EMUL_1;
        vl_i     = '0;
        vs1_i    = '0;
        vs2_i    = '0;
        fill_regs();
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        // idle for a few cycles with no request
        @(negedge clk_i);
        check_ack(op_ack_o, 1'b1);
        repeat (6) @(posedge clk_i);

        // every reduction at every width on one register at full length
        for (k = 1; k < 9; k++) begin
            for (s = 0; s < 3; s++) begin
                issue(elem_op_t'(k), sew_t'(s), EMUL_1, '1, rand_reg(), rand_reg());
                wait_drained();
            end
        end

        // larger groups with short vl where the first of each set has vl 0
        for (g = 1; g < 4; g++) begin
            for (s = 0; s < 3; s++) begin
                for (rep = 0; rep < 4; rep++) begin
                    emul = emul_t'(g);
                    sew  = sew_t'(s);
                    vl   = (rep == 0) ? '0 : VL_W'(rand_below(group_elems(sew, emul) + 2));
                    issue(elem_op_t'(1 + rand_below(8)), sew, emul, vl, rand_reg(),
                          aligned_reg(emul));
                    wait_drained();
                end
            end
        end

        // xmv at each width
        for (s = 0; s < 3; s++) begin
            for (rep = 0; rep < 4; rep++) begin
                issue(OP_XMV, sew_t'(s), EMUL_1, VL_W'(rand_below(256)), rand_reg(),
                      rand_reg());
                wait_drained();
            end
        end

        // back-to-back stream with op_rdy_i held high
        for (rep = 0; rep < STREAM_OPS; rep++) begin
            emul = emul_t'(rand_below(4));
            issue(elem_op_t'(rand_below(9)), sew_t'(rand_below(3)), emul,
                  VL_W'(rand_below(256)), rand_reg(), aligned_reg(emul));
        end
        wait_drained();

        @(negedge clk_i);
        check_ack(op_ack_o, 1'b1);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
